// ==== xt_peripherals.f ====
logic/xt_bus_pkg.sv
logic/ems_pkg.sv
logic/port_decoder.sv
logic/bus_cycle_fsm.sv
logic/timer_clock_gen.sv
logic/ems_mapper.sv
logic/chipset_readback.sv
logic/xt_peripherals.sv
bench/tb_xt_peripherals.sv

// ==== Bender.yml ====
package:
  name: xt_peripherals

sources:
  - files:
      - logic/xt_bus_pkg.sv
      - logic/ems_pkg.sv
      - logic/port_decoder.sv
      - logic/bus_cycle_fsm.sv
      - logic/timer_clock_gen.sv
      - logic/ems_mapper.sv
      - logic/chipset_readback.sv
      - logic/xt_peripherals.sv
  - target: test
    files:
      - bench/tb_xt_peripherals.sv

// ==== bench/tb_xt_peripherals.sv ====
// Testbench for the XT peripheral glue
// Random I/O and memory cycles checked against a model of the EMS pages,
// the parallel-port latch, the chip-select groups and the timer clock

`timescale 1ns/1ps

module tb_xt_peripherals
    import xt_bus_pkg::*;
    import ems_pkg::*;
();

    localparam int NUM_OPS        = 300;
    localparam int MAX_OP_CYCLES  = 9;
    localparam int PLANNED_CYCLES = 10 + (NUM_OPS + 5) * MAX_OP_CYCLES + 40;
    localparam int CYCLE_LIMIT    = 4 * PLANNED_CYCLES;

    logic                 clock;
    logic                 reset;
    addr_t                address_i;
    logic                 address_enable_n_i;
    logic                 io_read_n_i;
    logic                 io_write_n_i;
    data_t                data_i;
    logic                 ems_enabled_i;
    ems_window_t          ems_window_i;
    logic                 peripheral_clock_i;
    chip_sel_t            chip_sel_o;
    data_t                data_bus_out_o;
    logic                 data_from_chipset_o;
    logic [EMS_PAGES-1:0] ems_bank_o;
    logic                 timer_clock_o;

    // Reference model state
    logic [EMS_PAGES-1:0] model_enabled;
    ems_frame_t           model_frame [EMS_PAGES];
    data_t                model_lpt;

    int   cycle_count = 0;
    int   peripheral_rises = 0;
    int   timer_toggles = 0;
    logic timer_last = 1'b0;
    logic peripheral_run;
    logic peripheral_done;

    xt_peripherals dut (
        .clock               (clock),
        .reset               (reset),
        .address_i           (address_i),
        .address_enable_n_i  (address_enable_n_i),
        .io_read_n_i         (io_read_n_i),
        .io_write_n_i        (io_write_n_i),
        .data_i              (data_i),
        .ems_enabled_i       (ems_enabled_i),
        .ems_window_i        (ems_window_i),
        .peripheral_clock_i  (peripheral_clock_i),
        .chip_sel_o          (chip_sel_o),
        .data_bus_out_o      (data_bus_out_o),
        .data_from_chipset_o (data_from_chipset_o),
        .ems_bank_o          (ems_bank_o),
        .timer_clock_o       (timer_clock_o)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Count timer clock edges away from the DUT clock edge
    always @(negedge clock) begin
        if (!reset && timer_clock_o !== timer_last) begin
            timer_toggles++;
        end
        timer_last = timer_clock_o;
    end

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_byte(input data_t got, input data_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_chip_sel(input chip_sel_t got, input chip_sel_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_bank(input logic [EMS_PAGES-1:0] got, input logic [EMS_PAGES-1:0] exp,
                              input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    // Mapping registers sit at ports 260h to 263h
    function automatic logic is_ems_port(input addr_t a);
        return a[15:0] >= 16'h0260 && a[15:0] <= 16'h0263;
    endfunction

    // Group k of the low 256 ports selects chip k
    function automatic chip_sel_t expect_sel(input addr_t a, input logic aen_n);
        chip_sel_t sel;
        sel = '1;
        if (!aen_n && a[9:8] == 2'b00 && a[7:5] < 3'd5) begin
            sel[a[7:5]] = 1'b0;
        end
        return sel;
    endfunction

    function automatic logic [EMS_PAGES-1:0] expect_bank(input addr_t a, input ems_window_t w);
        logic [3:0]           base;
        logic [EMS_PAGES-1:0] bank;
        base = (w == 2'd0) ? 4'hA : (w == 2'd1) ? 4'hC : 4'hD;
        for (int n = 0; n < EMS_PAGES; n++) begin
            bank[n] = model_enabled[n] && a[19:16] == base && a[15:14] == 2'(n);
        end
        return bank;
    endfunction

    task automatic apply_write(input addr_t a, input data_t d, input logic aen_n,
                               input logic ems_en);
        if (aen_n) return;
        if (ems_en && is_ems_port(a)) begin
            if (d == 8'hFF) begin
                model_enabled[a[1:0]] = 1'b0;
            end else if (d < 8'h80) begin
                model_enabled[a[1:0]] = 1'b1;
                model_frame[a[1:0]]   = d[6:0];
            end
        end else if (a[15:0] == LPT_PORT_BASE) begin
            model_lpt = d;
        end
    endtask

    // Entered and left 2 ns after a rising clock edge
    task automatic io_cycle(input logic is_write, input addr_t a, input data_t d,
                            input logic aen_n, input logic ems_en,
                            input int strobe_len, input int gap_len);
        data_t       exp_data;
        logic        exp_flag;
        addr_t       mem;
        ems_window_t w;
        exp_data = 8'h00;
        exp_flag = 1'b0;
        if (!is_write && !aen_n && ems_en && is_ems_port(a)) begin
            exp_flag = 1'b1;
            exp_data = model_enabled[a[1:0]] ? {1'b0, model_frame[a[1:0]]} : 8'hFF;
        end else if (!is_write && !aen_n && a[15:0] == LPT_PORT_BASE) begin
            exp_flag = 1'b1;
            exp_data = model_lpt;
        end
        address_i          = a;
        data_i             = d;
        address_enable_n_i = aen_n;
        ems_enabled_i      = ems_en;
        io_write_n_i       = ~is_write;
        io_read_n_i        = is_write;
        repeat (strobe_len) begin
            @(negedge clock);
            check_chip_sel(chip_sel_o, expect_sel(a, aen_n), "chip select");
            check_byte(data_bus_out_o, exp_data, "read data");
            check_bit(data_from_chipset_o, exp_flag, "chipset data flag");
            @(posedge clock);
            #2;
        end
        io_write_n_i = 1'b1;
        io_read_n_i  = 1'b1;
        if (is_write) apply_write(a, d, aen_n, ems_en);
        // Idle gap with random memory addresses for the window decode
        for (int g = 0; g < gap_len; g++) begin
            mem = 20'($urandom);
            w   = ems_window_t'($urandom % 4);
            case ($urandom % 3)
                0:       mem[19:16] = 4'hA;
                1:       mem[19:16] = 4'hC;
                default: mem[19:16] = 4'hD;
            endcase
            address_i          = mem;
            ems_window_i       = w;
            address_enable_n_i = 1'b0;
            @(negedge clock);
            check_chip_sel(chip_sel_o, '1, "chip select while idle");
            check_byte(data_bus_out_o, 8'h00, "read data while idle");
            check_bit(data_from_chipset_o, 1'b0, "chipset data flag while idle");
            // Bus idle and last write applied from the third gap cycle on
            if (g >= 2) check_bank(ems_bank_o, expect_bank(mem, w), "EMS bank");
            @(posedge clock);
            #2;
        end
    endtask

    task automatic random_op();
        int    pick;
        addr_t a;
        data_t d;
        a = 20'($urandom);
        d = 8'($urandom);
        pick = $urandom % 8;
        if (pick < 3) begin
            a[15:0] = EMS_PORT_BASE | 16'($urandom % 4);
            case ($urandom % 4)
                0:       d = 8'hFF;
                1:       d = 8'h80 + 8'($urandom % 127);
                default: d = d & 8'h7F;
            endcase
        end else if (pick < 5) begin
            a[15:0] = LPT_PORT_BASE;
        end else if (pick < 7) begin
            a[15:0] = a[15:0] & 16'h03FF;
        end
        io_cycle(1'($urandom % 2), a, d, ($urandom % 8) == 0, ($urandom % 6) != 0,
                 1 + $urandom % 3, 2 + $urandom % 5);
    endtask

    // Slow peripheral clock, each phase 2 to 6 DUT clocks
    task automatic run_peripheral_clock();
        int hold;
        while (peripheral_run) begin
            hold = 2 + $urandom % 5;
            repeat (hold) @(posedge clock);
            #2;
            peripheral_clock_i = ~peripheral_clock_i;
            if (peripheral_clock_i) peripheral_rises++;
        end
        peripheral_done = 1'b1;
    endtask

    initial begin
        clock              = 1'b0;
        reset              = 1'b1;
        address_i          = '0;
        address_enable_n_i = 1'b0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b1;
        data_i             = '0;
        ems_enabled_i      = 1'b0;
        ems_window_i       = '0;
        peripheral_clock_i = 1'b0;
        peripheral_run     = 1'b1;
        peripheral_done    = 1'b0;
        model_enabled      = '0;
        model_lpt          = 8'hFF;
        for (int n = 0; n < EMS_PAGES; n++) model_frame[n] = '0;
        void'($urandom(11));
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_bit(timer_clock_o, 1'b0, "timer clock after reset");
        check_chip_sel(chip_sel_o, '1, "chip select after reset");
        @(posedge clock);
        #2;
        for (int p = 0; p < EMS_PAGES; p++) begin
            io_cycle(1'b0, 20'h00260 + 20'(p), 8'h00, 1'b0, 1'b1, 1, 2);
        end
        io_cycle(1'b0, 20'h00378, 8'h00, 1'b0, 1'b1, 1, 2);
        fork
            run_peripheral_clock();
        join_none
        for (int i = 0; i < NUM_OPS; i++) random_op();
        peripheral_run = 1'b0;
        wait (peripheral_done);
        repeat (4) @(posedge clock);
        #5;
        check_count(timer_toggles, peripheral_rises, "timer clock toggles");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== logic/xt_peripherals.sv ====
// XT peripherals
// Chipset glue for the XT: support-chip selects, EMS page mapping,
// parallel-port latch, read-back mux and the timer clock

`timescale 1ns/1ps

module xt_peripherals
    import xt_bus_pkg::*;
    import ems_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                address_i,
    input  logic                 address_enable_n_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  data_t                data_i,
    input  logic                 ems_enabled_i,
    input  ems_window_t          ems_window_i,
    input  logic                 peripheral_clock_i,
    output chip_sel_t            chip_sel_o,
    output data_t                data_bus_out_o,
    output logic                 data_from_chipset_o,
    output logic [EMS_PAGES-1:0] ems_bank_o,
    output logic                 timer_clock_o
);

    logic  ems_hit;
    logic  lpt_hit;
    logic  io_idle;
    logic  write_commit;
    data_t ems_read_data;

    port_decoder u_port_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .chip_sel_o         (chip_sel_o),
        .ems_hit_o          (ems_hit),
        .lpt_hit_o          (lpt_hit)
    );

    bus_cycle_fsm u_bus_cycle_fsm (
        .clock          (clock),
        .reset          (reset),
        .io_read_n_i    (io_read_n_i),
        .io_write_n_i   (io_write_n_i),
        .io_idle_o      (io_idle),
        .write_commit_o (write_commit)
    );

    timer_clock_gen u_timer_clock_gen (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    ems_mapper u_ems_mapper (
        .clock          (clock),
        .reset          (reset),
        .address_i      (address_i),
        .data_i         (data_i),
        .io_write_n_i   (io_write_n_i),
        .ems_hit_i      (ems_hit),
        .write_commit_i (write_commit),
        .io_idle_i      (io_idle),
        .ems_window_i   (ems_window_i),
        .read_data_o    (ems_read_data),
        .ems_bank_o     (ems_bank_o)
    );

    chipset_readback u_chipset_readback (
        .clock               (clock),
        .reset               (reset),
        .data_i              (data_i),
        .io_read_n_i         (io_read_n_i),
        .io_write_n_i        (io_write_n_i),
        .ems_hit_i           (ems_hit),
        .lpt_hit_i           (lpt_hit),
        .write_commit_i      (write_commit),
        .ems_data_i          (ems_read_data),
        .data_bus_out_o      (data_bus_out_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule

// ==== logic/chipset_readback.sv ====
// Chipset read-back
// Parallel-port data latch at 378h and the read data mux that drives
// the system bus during EMS and LPT reads

`timescale 1ns/1ps

module chipset_readback
    import xt_bus_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  data_t data_i,
    input  logic  io_read_n_i,
    input  logic  io_write_n_i,
    input  logic  ems_hit_i,
    input  logic  lpt_hit_i,
    input  logic  write_commit_i,
    input  data_t ems_data_i,
    output data_t data_bus_out_o,
    output logic  data_from_chipset_o
);

    data_t lpt_data;
    data_t lpt_capture;
    logic  lpt_pending;

    always_ff @(posedge clock) begin
        if (!io_write_n_i && lpt_hit_i) begin
            lpt_capture <= data_i;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_pending <= 1'b0;
            lpt_data    <= LPT_RESET_VALUE;
        end else begin
            if (!io_write_n_i && lpt_hit_i) begin
                lpt_pending <= 1'b1;
            end else if (write_commit_i) begin
                lpt_pending <= 1'b0;
            end
            // Latch updates once the write strobe has gone away
            if (write_commit_i && lpt_pending) begin
                lpt_data <= lpt_capture;
            end
        end
    end

    always_comb begin
        data_bus_out_o      = '0;
        data_from_chipset_o = 1'b0;
        if (!io_read_n_i && ems_hit_i) begin
            data_bus_out_o      = ems_data_i;
            data_from_chipset_o = 1'b1;
        end else if (!io_read_n_i && lpt_hit_i) begin
            data_bus_out_o      = lpt_data;
            data_from_chipset_o = 1'b1;
        end
    end

endmodule

// ==== logic/ems_mapper.sv ====
// EMS mapper
// Four page-mapping registers written through ports 260h..263h, plus
// decode of the selected memory window into per-page bank hits

`timescale 1ns/1ps

module ems_mapper
    import xt_bus_pkg::*;
    import ems_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                address_i,
    input  data_t                data_i,
    input  logic                 io_write_n_i,
    input  logic                 ems_hit_i,
    input  logic                 write_commit_i,
    input  logic                 io_idle_i,
    input  ems_window_t          ems_window_i,
    output data_t                read_data_o,
    output logic [EMS_PAGES-1:0] ems_bank_o
);

    ems_frame_t           frame [EMS_PAGES];
    logic [EMS_PAGES-1:0] page_enabled;
    logic                 write_pending;
    ems_index_t           write_index;
    data_t                write_data;
    ems_index_t           read_index;
    logic [3:0]           window_base;

    // Hold the last port and byte seen while the strobe is low
    always_ff @(posedge clock) begin
        if (!io_write_n_i && ems_hit_i) begin
            write_index <= address_i[1:0];
            write_data  <= data_i;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_pending <= 1'b0;
            page_enabled  <= '0;
            for (int n = 0; n < EMS_PAGES; n++) begin
                frame[n] <= '0;
            end
        end else begin
            if (!io_write_n_i && ems_hit_i) begin
                write_pending <= 1'b1;
            end else if (write_commit_i) begin
                write_pending <= 1'b0;
            end
            if (write_commit_i && write_pending) begin
                if (write_data == EMS_DISABLE_CODE) begin
                    page_enabled[write_index] <= 1'b0;
                end else if (write_data < EMS_FRAME_LIMIT) begin
                    page_enabled[write_index] <= 1'b1;
                    frame[write_index]        <= write_data[6:0];
                end
            end
        end
    end

    assign read_index  = address_i[1:0];
    assign read_data_o = page_enabled[read_index] ? {1'b0, frame[read_index]} : EMS_READ_EMPTY;

    // Window base: 0 -> A0000h, 1 -> C0000h, others -> D0000h
    always_comb begin
        case (ems_window_i)
            2'd0:    window_base = EMS_WINDOW_A;
            2'd1:    window_base = EMS_WINDOW_C;
            default: window_base = EMS_WINDOW_D;
        endcase
    end

    // Each page covers 16 KB of the window
    always_comb begin
        for (int n = 0; n < EMS_PAGES; n++) begin
            ems_bank_o[n] = io_idle_i & page_enabled[n] &
                            (address_i[19:14] == {window_base, ems_index_t'(n)});
        end
    end

endmodule

// ==== logic/timer_clock_gen.sv ====
// Timer clock generator
// Synchronizes the peripheral clock and halves it to clock the
// external 8253

`timescale 1ns/1ps

module timer_clock_gen (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    logic sync_first;
    logic sync_second;
    logic rising;

    assign rising = sync_first & ~sync_second;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_first    <= 1'b0;
            sync_second   <= 1'b0;
            timer_clock_o <= 1'b0;
        end else begin
            sync_first  <= peripheral_clock_i;
            sync_second <= sync_first;
            // One toggle per peripheral clock period
            if (rising) begin
                timer_clock_o <= ~timer_clock_o;
            end
        end
    end

endmodule

// ==== logic/bus_cycle_fsm.sv ====
// Bus cycle state machine
// Follows the I/O read and write strobes and pulses a commit for one
// clock when a write cycle ends

`timescale 1ns/1ps

module bus_cycle_fsm
    import xt_bus_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic io_read_n_i,
    input  logic io_write_n_i,
    output logic io_idle_o,
    output logic write_commit_o
);

    bus_state_t state;
    bus_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: begin
                if (!io_write_n_i) begin
                    state_next = BUS_WRITE;
                end else if (!io_read_n_i) begin
                    state_next = BUS_READ;
                end
            end
            BUS_WRITE: begin
                if (io_write_n_i) begin
                    state_next = BUS_IDLE;
                end
            end
            BUS_READ: begin
                if (io_read_n_i) begin
                    state_next = BUS_IDLE;
                end
            end
            default: state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= BUS_IDLE;
            write_commit_o <= 1'b0;
        end else begin
            state          <= state_next;
            // Strobe seen high again while in a write
            write_commit_o <= (state == BUS_WRITE) && io_write_n_i;
        end
    end

    assign io_idle_o = (state == BUS_IDLE);

endmodule

// ==== logic/port_decoder.sv ====
// Port decoder
// Chip selects for the five XT support chips and hits for the EMS
// and parallel-port registers, decoded from the I/O address

`timescale 1ns/1ps

module port_decoder
    import xt_bus_pkg::*;
(
    input  addr_t     address_i,
    input  logic      address_enable_n_i,
    input  logic      io_read_n_i,
    input  logic      io_write_n_i,
    input  logic      ems_enabled_i,
    output chip_sel_t chip_sel_o,
    output logic      ems_hit_o,
    output logic      lpt_hit_o
);

    port_addr_t port;
    logic       io_access;
    logic       low_space;

    assign port = address_i[15:0];

    // CPU-driven I/O cycle with a strobe asserted
    assign io_access = ~address_enable_n_i & (~io_read_n_i | ~io_write_n_i);

    // Support chips live below 100h
    assign low_space = ~address_i[9] & ~address_i[8];

    always_comb begin
        chip_sel_o = '1;
        if (io_access && low_space) begin
            for (int k = 0; k < $bits(chip_sel_t); k++) begin
                if (address_i[CHIP_GROUP_LSB +: 3] == 3'(k)) begin
                    chip_sel_o[k] = 1'b0;
                end
            end
        end
    end

    // Four consecutive EMS ports, only when the mapper is switched on
    assign ems_hit_o = io_access & ems_enabled_i &
                       (port[15:2] == EMS_PORT_BASE[15:2]);

    assign lpt_hit_o = io_access & (port == LPT_PORT_BASE);

endmodule

// ==== logic/ems_pkg.sv ====
// EMS package
// Page count, mapping types and memory window codes of the EMS mapper

package ems_pkg;

    localparam int EMS_PAGES = 4;

    typedef logic [1:0] ems_index_t;
    typedef logic [6:0] ems_frame_t;
    typedef logic [1:0] ems_window_t;

    // Upper address nibble of each selectable window
    localparam logic [3:0] EMS_WINDOW_A = 4'hA;
    localparam logic [3:0] EMS_WINDOW_C = 4'hC;
    localparam logic [3:0] EMS_WINDOW_D = 4'hD;

    // Write codes for the mapping registers
    localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
    localparam logic [7:0] EMS_FRAME_LIMIT  = 8'h80;

    // Read value of a disabled page
    localparam logic [7:0] EMS_READ_EMPTY = 8'hFF;

endpackage

// ==== logic/xt_bus_pkg.sv ====
// XT bus package
// Bus widths, I/O port bases and the bus-cycle states shared by the
// peripheral glue

package xt_bus_pkg;

    // System address, I/O port address and bus byte
    typedef logic [19:0] addr_t;
    typedef logic [15:0] port_addr_t;
    typedef logic [7:0]  data_t;

    // Active-low selects, bit 0 DMA, then PIC, PIT, PPI, DMA page
    typedef logic [4:0]  chip_sel_t;

    // EMS mapping registers occupy 260h to 263h
    localparam port_addr_t EMS_PORT_BASE = 16'h0260;

    // Parallel-port data latch
    localparam port_addr_t LPT_PORT_BASE = 16'h0378;

    // Address bits 7..5 pick one of the chip groups
    localparam int CHIP_GROUP_LSB = 5;

    localparam data_t LPT_RESET_VALUE = 8'hFF;

    // I/O bus cycle in progress
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_READ,
        BUS_WRITE
    } bus_state_t;

endpackage
